// ==== common/mem_map_pkg.sv ====
// Local memory map constants, control register numbers and the bus address union
package mem_map_pkg;

	// Byte address width of the memory bus
	localparam int addr_w = 24;

	// Upper address bits 23:15 of the local window
	// Graphics window f02000-f07fff, bits 14:13 must also be nonzero
	localparam logic [8:0] gfx_local_page = 9'b1111_0000_0;
	// Audio window f18000-f1ffff covers the whole page
	localparam logic [8:0] dsp_local_page = 9'b1111_0001_1;

	// Region codes in bits 14:12
	localparam logic [2:0] ram0_region = 3'd3;
	localparam logic [2:0] ram1_region = 3'd4;
	localparam logic [2:0] rom_region = 3'd5;

	// Control block in bits 14:9, blitter in bits 14:8
	localparam logic [5:0] ctrl_block = 6'b010000;
	localparam logic [6:0] blit_block = 7'h22;
	// Register group inside the control block, bits 8:7
	localparam logic [1:0] ctrl_group = 2'b10;

	// Register numbers in bits 6:2
	typedef enum logic [4:0] {
		reg_flags = 5'd0,
		reg_mtxc = 5'd1,
		reg_mtxa = 5'd2,
		reg_endian = 5'd3,
		reg_pc = 5'd4,
		reg_ctrl = 5'd5,
		// hidata on graphics, modulo on audio
		reg_hidata = 5'd6,
		// Divide on write, remainder on read
		reg_div = 5'd7,
		reg_accum = 5'd8,
		reg_dac0 = 5'd16,
		reg_dac1 = 5'd17,
		reg_i2s0 = 5'd18,
		reg_i2s1 = 5'd19,
		reg_i2s2 = 5'd20,
		reg_i2s3 = 5'd21
	} reg_idx_e;

	// Address seen as a RAM or ROM access
	typedef struct packed {
		logic [8:0] page;
		logic [2:0] region;
		logic [11:0] offset;
	} ram_view_t;

	// Address seen as a control register access, group[1] is the bit 8 select
	typedef struct packed {
		logic [8:0] page;
		logic [5:0] block;
		logic [1:0] group;
		reg_idx_e idx;
		logic [1:0] byte_sel;
	} reg_view_t;

	typedef union packed {
		ram_view_t ram;
		reg_view_t regs;
	} mem_addr_u;

endpackage

// ==== common/bus_pkg.sv ====
// Requester numbering, data width and endian control bit positions
package bus_pkg;

	// Width of the memory data bus
	localparam int data_w = 32;

	// Bus requesters, listed in falling priority
	typedef enum logic [1:0] {
		// Host CPU
		req_io = 2'd0,
		// Gateway to external memory
		req_gate = 2'd1,
		// Load/store unit
		req_data = 2'd2,
		// Instruction prefetch
		req_prog = 2'd3
	} requester_e;

	// Bits of the endian control register
	// Big endian for host CPU accesses
	localparam int big_io_bit = 0;
	// Big endian pixel packing
	localparam int big_pix_bit = 1;
	// Big endian instruction fetch
	localparam int big_instr_bit = 2;

	// Reset values of the endian bits
	localparam logic big_io_init = 1'b1;
	localparam logic big_pix_init = 1'b1;
	localparam logic big_instr_init = 1'b0;

endpackage

// ==== common/grant_if.sv ====
// Registered bus grants and the external cycle flag shared between the controller blocks
`timescale 1ns/1ps

interface grant_if;

	// One grant per requester, at most one high
	logic ioserv;
	logic gateserv;
	logic datserv;
	logic progserv;
	// Data or prog grant that leaves the local window
	logic external;

	modport arbiter (
		output ioserv, gateserv, datserv, progserv,
		input external
	);

	// Gateway cycles go to external memory and never decode locally
	modport decoder (
		input ioserv, datserv, progserv,
		output external
	);

	modport datapath (
		input ioserv, gateserv, datserv, progserv, external
	);

endinterface

// ==== arbiter/mem_arbiter.sv ====
// Fixed priority bus arbiter with grant registers, external fetch tracking and acks
`timescale 1ns/1ps

module mem_arbiter (
	input logic sys_clk,
	input logic resetl,
	input logic ioreq,
	input logic gatereq,
	input logic datreq,
	input logic progreq,
	input logic pabort,
	input logic datwe,
	input logic iowr,
	grant_if.arbiter gnt,
	output logic gpu_memw,
	output logic progack,
	output logic datack,
	output logic gateack,
	output logic del_xld
);

	bus_pkg::requester_e winner;
	logic win_valid;
	logic memw_next;
	// Program fetch waiting for the gateway
	logic xprog;
	logic xprog_set;
	logic xprog_next;
	// Outstanding fetch was given up by the prefetcher
	logic xpabort;
	logic xpabort_next;
	// External fetch either pending or starting now
	logic xprt;

	// Start an external fetch when prog goes outside the window
	assign xprog_set = gnt.progserv & gnt.external & ~pabort;
	// Cleared when the gateway is served
	assign xprog_next = xprog_set | (xprog & ~gnt.gateserv);
	// Request dropped while the fetch is still out
	assign xpabort_next = (xprog & ~progreq & ~gnt.gateserv) | (xpabort & ~gnt.gateserv);

	// Priority io > gate > data > prog
	// Prog waits while a fetch is pending, including one that starts this cycle
	always_comb begin
		win_valid = 1'b1;
		winner = bus_pkg::req_io;
		if (ioreq)
			winner = bus_pkg::req_io;
		else if (gatereq)
			winner = bus_pkg::req_gate;
		else if (datreq)
			winner = bus_pkg::req_data;
		else if (progreq && !xprog_next)
			winner = bus_pkg::req_prog;
		else
			win_valid = 1'b0;
	end

	// Write cycle only for host writes and data stores
	assign memw_next = win_valid &
		(((winner == bus_pkg::req_io) & iowr) | ((winner == bus_pkg::req_data) & datwe));

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			gnt.ioserv <= 1'b0;
			gnt.gateserv <= 1'b0;
			gnt.datserv <= 1'b0;
			gnt.progserv <= 1'b0;
			gpu_memw <= 1'b0;
			xprog <= 1'b0;
			xpabort <= 1'b0;
		end else begin
			gnt.ioserv <= win_valid && (winner == bus_pkg::req_io);
			gnt.gateserv <= win_valid && (winner == bus_pkg::req_gate);
			gnt.datserv <= win_valid && (winner == bus_pkg::req_data);
			gnt.progserv <= win_valid && (winner == bus_pkg::req_prog);
			gpu_memw <= memw_next;
			xprog <= xprog_next;
			xpabort <= xpabort_next;
		end
	end

	assign xprt = xprog | xprog_set;

	// Local fetch acks at once, external fetch acks when the gateway completes it
	assign progack = (~xprt & gnt.progserv & ~pabort) | (xprt & gnt.gateserv & ~xpabort);
	assign datack = gnt.datserv;
	assign gateack = gnt.gateserv;
	// External data read, the gateway returns the data later
	assign del_xld = gnt.datserv & gnt.external & ~datwe;

	// No two requesters own the bus together
	a_grant_onehot: assert property (@(posedge sys_clk) disable iff (!resetl)
		$onehot0({gnt.ioserv, gnt.gateserv, gnt.datserv, gnt.progserv}));

	// A pending fetch holds off the prefetcher until the gateway cycle
	a_no_prog_while_xprog: assert property (@(posedge sys_clk) disable iff (!resetl)
		(xprog && !gnt.gateserv) |=> !gnt.progserv);

endmodule

// ==== decode/addr_decode.sv ====
// Bus address mux, local window test and RAM, ROM, blitter and register strobe decode
`timescale 1ns/1ps

module addr_decode #(
	parameter int DSP_VARIANT = 0
) (
	grant_if.decoder gnt,
	input logic [12:0] cpuaddr,
	input logic [mem_map_pkg::addr_w-1:0] dataddr,
	input logic [21:0] progaddr,
	input logic gpu_memw,
	input logic go,
	input logic lock,
	output logic [mem_map_pkg::addr_w-1:0] gpu_addr,
	output logic [11:2] ram_addr,
	output logic [1:0] ramen,
	output logic romen,
	output logic bliten,
	output logic flagwr,
	output logic mtxcwr,
	output logic mtxawr,
	output logic pcwr,
	output logic ctrlwr,
	output logic ctrlwrgo,
	output logic hidwr,
	output logic modulowr,
	output logic divwr,
	output logic [1:0] dacw,
	output logic [3:0] i2sw,
	output logic flagrd,
	output logic pcrd,
	output logic statrd,
	output logic hidrd,
	output logic remrd,
	output logic accumrd,
	output logic dbgrd,
	output logic [2:0] i2sr,
	output logic bigwr,
	output logic cpu_rd_ctrl
);

	localparam logic is_dsp = (DSP_VARIANT != 0);
	localparam logic [8:0] local_page = is_dsp ? mem_map_pkg::dsp_local_page
		: mem_map_pkg::gfx_local_page;

	mem_map_pkg::mem_addr_u addr_u;
	mem_map_pkg::reg_idx_e idx;
	// Address bits 14:2 from the granted source
	logic [12:0] src_mid;
	logic [8:0] src_page;
	logic [1:0] src_low;
	logic fetch_cyc;
	logic in_window;
	logic local_cyc;
	logic dis;
	logic ctrl_hit;
	logic gpuictrl;
	logic gpuireg;
	logic reg_wr;
	logic reg_rd;

	// Host address is a 13 bit word address, prog a 22 bit word address
	always_comb begin
		if (gnt.ioserv)
			src_mid = cpuaddr;
		else if (gnt.datserv)
			src_mid = dataddr[14:2];
		else
			src_mid = progaddr[12:0];
	end

	// Host cycles keep the prog page on the upper bits
	assign src_page = gnt.datserv ? dataddr[23:15] : progaddr[21:13];
	// Only byte accesses from the load/store unit
	assign src_low = gnt.datserv ? dataddr[1:0] : 2'b00;

	assign addr_u = {src_page, src_mid, src_low};
	assign gpu_addr = addr_u;
	assign ram_addr = addr_u.ram.offset[11:2];

	// Window test on data and prog cycles only
	assign fetch_cyc = gnt.datserv | gnt.progserv;
	assign in_window = (addr_u.ram.page == local_page) & (is_dsp | (|addr_u.ram.region[2:1]));
	assign gnt.external = fetch_cyc & ~in_window;
	// Host cycles always decode locally
	assign local_cyc = gnt.ioserv | (fetch_cyc & in_window);

	// Register lock shuts the host out, graphics only
	assign dis = ~is_dsp & gnt.ioserv & lock;

	// Region enables from the RAM view
	assign ramen[0] = local_cyc & (addr_u.ram.region == mem_map_pkg::ram0_region) & ~dis;
	assign ramen[1] = local_cyc & (addr_u.ram.region == mem_map_pkg::ram1_region);
	assign romen = local_cyc & (addr_u.ram.region == mem_map_pkg::rom_region);

	// Blitter and control block from the register view
	assign bliten = local_cyc & ({addr_u.regs.block, addr_u.regs.group[1]} == mem_map_pkg::blit_block)
		& ~dis;
	assign ctrl_hit = local_cyc & (addr_u.regs.block == mem_map_pkg::ctrl_block);

	// CPU reads out of the lower half of the control block
	assign cpu_rd_ctrl = ctrl_hit & ~addr_u.regs.group[1] & ~go & ~gpu_memw;

	assign gpuictrl = ctrl_hit & (addr_u.regs.group == mem_map_pkg::ctrl_group);
	assign gpuireg = gpuictrl & ~dis;
	assign reg_wr = gpuireg & gpu_memw;
	assign reg_rd = gpuireg & ~gpu_memw;
	assign idx = addr_u.regs.idx;

	// Write strobes
	assign flagwr = reg_wr & (idx == mem_map_pkg::reg_flags);
	assign mtxcwr = reg_wr & (idx == mem_map_pkg::reg_mtxc);
	assign mtxawr = reg_wr & (idx == mem_map_pkg::reg_mtxa);
	assign bigwr = reg_wr & (idx == mem_map_pkg::reg_endian);
	assign pcwr = reg_wr & (idx == mem_map_pkg::reg_pc);
	assign ctrlwr = reg_wr & (idx == mem_map_pkg::reg_ctrl);
	// Go bit write passes the lock so a locked part can still be started
	assign ctrlwrgo = ~is_dsp & gpuictrl & gpu_memw & (idx == mem_map_pkg::reg_ctrl);
	// Same index, hidata on graphics and modulo on audio
	assign hidwr = ~is_dsp & reg_wr & (idx == mem_map_pkg::reg_hidata);
	assign modulowr = is_dsp & reg_wr & (idx == mem_map_pkg::reg_hidata);
	assign divwr = reg_wr & (idx == mem_map_pkg::reg_div);
	assign dacw[0] = is_dsp & reg_wr & (idx == mem_map_pkg::reg_dac0);
	assign dacw[1] = is_dsp & reg_wr & (idx == mem_map_pkg::reg_dac1);
	// Left and right transmit data, serial clock, serial mode
	assign i2sw[0] = is_dsp & reg_wr & (idx == mem_map_pkg::reg_i2s0);
	assign i2sw[1] = is_dsp & reg_wr & (idx == mem_map_pkg::reg_i2s1);
	assign i2sw[2] = is_dsp & reg_wr & (idx == mem_map_pkg::reg_i2s2);
	assign i2sw[3] = is_dsp & reg_wr & (idx == mem_map_pkg::reg_i2s3);

	// Read strobes
	assign flagrd = reg_rd & (idx == mem_map_pkg::reg_flags);
	assign pcrd = reg_rd & (idx == mem_map_pkg::reg_pc);
	// Control index reads back status
	assign statrd = reg_rd & (idx == mem_map_pkg::reg_ctrl);
	assign hidrd = ~is_dsp & reg_rd & (idx == mem_map_pkg::reg_hidata);
	assign remrd = reg_rd & (idx == mem_map_pkg::reg_div);
	assign accumrd = is_dsp & reg_rd & (idx == mem_map_pkg::reg_accum);
	assign i2sr[0] = is_dsp & reg_rd & (idx == mem_map_pkg::reg_i2s0);
	assign i2sr[1] = is_dsp & reg_rd & (idx == mem_map_pkg::reg_i2s1);
	assign i2sr[2] = is_dsp & reg_rd & (idx == mem_map_pkg::reg_i2s2);
	// Debug port sees flag and status reads
	assign dbgrd = flagrd | statrd;

	// Each register access hits one register, go write aside
	always_comb begin
		assert ($onehot0({flagwr, mtxcwr, mtxawr, bigwr, pcwr, ctrlwr, hidwr, modulowr, divwr,
			dacw, i2sw, flagrd, pcrd, statrd, hidrd, remrd, accumrd, i2sr}))
			else $error("addr_decode: more than one register strobe");
	end

endmodule

// ==== rtl/bus_datapath.sv ====
// Write data mux, store and read data registers, endian control register and register lock
`timescale 1ns/1ps

module bus_datapath (
	input logic sys_clk,
	input logic resetl,
	grant_if.datapath gnt,
	input logic [bus_pkg::data_w-1:0] cpudata,
	input logic [bus_pkg::data_w-1:0] dstd,
	input logic dstdgate,
	input logic go,
	input logic [bus_pkg::data_w-1:0] gpu_din,
	input logic bigwr,
	input logic cpu_rd_ctrl,
	input logic gpu_memw,
	input logic reset_lock,
	output logic [bus_pkg::data_w-1:0] gpu_data_out,
	output logic gpu_data_oe,
	output logic [bus_pkg::data_w-1:0] mem_data,
	output logic big_io,
	output logic big_pix,
	output logic big_instr,
	output logic lock
);

	// Store data from the load/store unit
	logic [bus_pkg::data_w-1:0] datdata;
	logic cpudsel;
	logic bus_idle;

	// Load while running unless the store data is held off
	always_ff @(posedge sys_clk) begin
		if (go && !dstdgate)
			datdata <= dstd;
	end

	// Host drives the bus on its own cycles except for control block reads
	assign cpudsel = gnt.ioserv & ~cpu_rd_ctrl;
	assign gpu_data_out = cpudsel ? cpudata : datdata;

	assign bus_idle = ~(gnt.ioserv | gnt.gateserv | gnt.datserv | gnt.progserv);
	// Drive on writes, local reads to the CPU, idle and external cycles
	assign gpu_data_oe = gpu_memw | cpu_rd_ctrl | bus_idle | gnt.external;

	// Read data one cycle after the bus
	always_ff @(posedge sys_clk) begin
		mem_data <= gpu_din;
	end

	// Endian control register
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			big_io <= bus_pkg::big_io_init;
			big_pix <= bus_pkg::big_pix_init;
			big_instr <= bus_pkg::big_instr_init;
		end else if (bigwr) begin
			big_io <= gpu_din[bus_pkg::big_io_bit];
			big_pix <= gpu_din[bus_pkg::big_pix_bit];
			big_instr <= gpu_din[bus_pkg::big_instr_bit];
		end
	end

	// Lock follows the strap during reset, first endian write releases it
	always_ff @(posedge sys_clk) begin
		if (!resetl)
			lock <= reset_lock;
		else if (bigwr)
			lock <= 1'b0;
	end

endmodule

// ==== rtl/gpu_mem_top.sv ====
// Local memory controller top level with plain ports, grant interface and the three blocks
`timescale 1ns/1ps

module gpu_mem_top #(
	parameter int DSP_VARIANT = 0
) (
	input logic sys_clk,
	input logic resetl,
	input logic reset_lock,
	input logic ioreq,
	input logic iowr,
	input logic gatereq,
	input logic datreq,
	input logic datwe,
	input logic progreq,
	input logic pabort,
	input logic go,
	input logic [12:0] cpuaddr,
	input logic [mem_map_pkg::addr_w-1:0] dataddr,
	input logic [21:0] progaddr,
	input logic [bus_pkg::data_w-1:0] cpudata,
	input logic [bus_pkg::data_w-1:0] dstd,
	input logic dstdgate,
	input logic [bus_pkg::data_w-1:0] gpu_din,
	output logic [bus_pkg::data_w-1:0] gpu_data_out,
	output logic gpu_data_oe,
	output logic [bus_pkg::data_w-1:0] mem_data,
	output logic [mem_map_pkg::addr_w-1:0] gpu_addr,
	output logic [11:2] ram_addr,
	output logic gpu_memw,
	output logic externalb,
	output logic progserv,
	output logic progack,
	output logic datack,
	output logic gateack,
	output logic del_xld,
	output logic [1:0] ramen,
	output logic romen,
	output logic bliten,
	output logic flagwr,
	output logic mtxcwr,
	output logic mtxawr,
	output logic pcwr,
	output logic ctrlwr,
	output logic ctrlwrgo,
	output logic hidwr,
	output logic modulowr,
	output logic divwr,
	output logic [1:0] dacw,
	output logic [3:0] i2sw,
	output logic flagrd,
	output logic pcrd,
	output logic statrd,
	output logic hidrd,
	output logic remrd,
	output logic accumrd,
	output logic dbgrd,
	output logic [2:0] i2sr,
	output logic big_io,
	output logic big_pix,
	output logic big_instr,
	output logic lock
);

	// Endian register write and CPU control read, decoder to datapath
	logic bigwr;
	logic cpu_rd_ctrl;

	grant_if gnt ();

	// Execute stage
	mem_arbiter u_arbiter (
		.gnt(gnt),
		.*
	);

	// Decode stage
	addr_decode #(
		.DSP_VARIANT(DSP_VARIANT)
	) u_decode (
		.gnt(gnt),
		.*
	);

	// Result stage
	bus_datapath u_datapath (
		.gnt(gnt),
		.*
	);

	assign externalb = gnt.external;
	assign progserv = gnt.progserv;

endmodule

// ==== verif/tb_gpu_mem.sv ====
// Testbench for the local memory controller with LFSR stimulus, reference model and assertions
`timescale 1ns/1ps

module tb_gpu_mem;

	localparam int dsp_variant = 0;
	localparam int reset_cycles = 8;
	localparam int rand_cycles = 400;
	// Two resets, two random runs, directed fetch and drain
	localparam int planned_cycles = 2 * reset_cycles + 2 * rand_cycles + 24;
	localparam int timeout_cycles = 2 * planned_cycles;

	logic sys_clk = 1'b0;
	logic resetl, reset_lock;
	logic ioreq, iowr, gatereq, datreq, datwe, progreq, pabort, go, dstdgate;
	logic [12:0] cpuaddr;
	logic [mem_map_pkg::addr_w-1:0] dataddr;
	logic [21:0] progaddr;
	logic [bus_pkg::data_w-1:0] cpudata, dstd, gpu_din;
	logic [bus_pkg::data_w-1:0] gpu_data_out, mem_data;
	logic gpu_data_oe;
	logic [mem_map_pkg::addr_w-1:0] gpu_addr;
	logic [11:2] ram_addr;
	logic gpu_memw, externalb, progserv, progack, datack, gateack, del_xld;
	logic [1:0] ramen;
	logic romen, bliten;
	logic flagwr, mtxcwr, mtxawr, pcwr, ctrlwr, ctrlwrgo, hidwr, modulowr, divwr;
	logic [1:0] dacw;
	logic [3:0] i2sw;
	logic flagrd, pcrd, statrd, hidrd, remrd, accumrd, dbgrd;
	logic [2:0] i2sr;
	logic big_io, big_pix, big_instr, lock;

	logic [31:0] lfsr_state;
	int error_count = 0;
	int cycle_count = 0;

	// Reference model state, one grant per requester
	logic exp_io, exp_gate, exp_dat, exp_prog, exp_memw;
	logic exp_xprog, exp_xpabort, exp_lock;
	// Endian bits as instr, pix, io
	logic [2:0] exp_big;
	logic [bus_pkg::data_w-1:0] exp_dstd;
	mem_map_pkg::mem_addr_u ref_addr;
	logic in_window, exp_ext, local_cyc, locked_out, ctrl_sel, reg_en, exp_bigwr;
	logic exp_xprt, exp_progack, xprog_next;
	logic exp_ctrl_rd, exp_oe;
	logic [7:0] exp_wr, exp_rd, wr_vec, rd_vec;
	logic [3:0] exp_mem_en;

	gpu_mem_top #(
		.DSP_VARIANT(dsp_variant)
	) DUT (
		.*
	);

	always #4 sys_clk = ~sys_clk;

	// Strobes placed at their register number, endian write is internal
	assign wr_vec = {divwr, hidwr, ctrlwr, pcwr, 1'b0, mtxawr, mtxcwr, flagwr};
	assign rd_vec = {remrd, hidrd, statrd, pcrd, 3'b000, flagrd};

	// Right shift Galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic draw(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic fail_check(input string msg);
		error_count++;
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
	endtask

	// Address as the bus sees it in the current grant
	always_comb begin
		if (exp_io)
			ref_addr = {progaddr[21:13], cpuaddr, 2'b00};
		else if (exp_dat)
			ref_addr = dataddr;
		else
			ref_addr = {progaddr, 2'b00};
		// Graphics window f02000-f07fff, audio window is its whole page
		if (dsp_variant != 0)
			in_window = ref_addr.ram.page == mem_map_pkg::dsp_local_page;
		else
			in_window = (ref_addr.ram.page == mem_map_pkg::gfx_local_page)
				&& (ref_addr[14:0] >= 15'h2000);
		exp_ext = (exp_dat || exp_prog) && !in_window;
		local_cyc = exp_io || ((exp_dat || exp_prog) && in_window);
		// Lock only shuts out the host on graphics
		locked_out = (dsp_variant == 0) && exp_io && exp_lock;
		ctrl_sel = local_cyc && (ref_addr.regs.block == mem_map_pkg::ctrl_block)
			&& (ref_addr.regs.group == mem_map_pkg::ctrl_group);
		reg_en = ctrl_sel && !locked_out;
		// Register numbers past 7 shift out, none of them exist on graphics
		exp_wr = (reg_en && exp_memw) ? ((8'b1 << ref_addr.regs.idx) & 8'hF7) : 8'h00;
		exp_rd = (reg_en && !exp_memw) ? ((8'b1 << ref_addr.regs.idx) & 8'hF1) : 8'h00;
		exp_bigwr = reg_en && exp_memw && (ref_addr.regs.idx == mem_map_pkg::reg_endian);
		exp_mem_en[3] = local_cyc && (ref_addr.ram.region == mem_map_pkg::ram1_region);
		exp_mem_en[2] = local_cyc && (ref_addr.ram.region == mem_map_pkg::ram0_region)
			&& !locked_out;
		exp_mem_en[1] = local_cyc && (ref_addr.ram.region == mem_map_pkg::rom_region);
		exp_mem_en[0] = local_cyc && !locked_out
			&& ({ref_addr.regs.block, ref_addr.regs.group[1]} == mem_map_pkg::blit_block);
		// External fetch outstanding or starting in this prog grant
		exp_xprt = exp_xprog || (exp_prog && exp_ext && !pabort);
		exp_progack = (!exp_xprt && exp_prog && !pabort)
			|| (exp_xprt && exp_gate && !exp_xpabort);
		xprog_next = (exp_prog && exp_ext && !pabort) || (exp_xprog && !exp_gate);
		// Read from the lower half of the control block while the core is stopped
		exp_ctrl_rd = local_cyc && (ref_addr.regs.block == mem_map_pkg::ctrl_block)
			&& !ref_addr.regs.group[1] && !go && !exp_memw;
		// Bus driven on writes, those reads, idle cycles and external cycles
		exp_oe = exp_memw || exp_ctrl_rd || exp_ext
			|| !(exp_io || exp_gate || exp_dat || exp_prog);
	end

	always @(posedge sys_clk) begin
		if (go && !dstdgate)
			exp_dstd <= dstd;
		if (!resetl) begin
			{exp_io, exp_gate, exp_dat, exp_prog, exp_memw} <= 5'b0;
			exp_xprog <= 1'b0;
			exp_xpabort <= 1'b0;
			exp_big <= 3'b011;
			exp_lock <= reset_lock;
		end else begin
			exp_io <= ioreq;
			exp_gate <= !ioreq && gatereq;
			exp_dat <= !ioreq && !gatereq && datreq;
			exp_prog <= !ioreq && !gatereq && !datreq && progreq && !xprog_next;
			exp_memw <= (ioreq && iowr) || (!ioreq && !gatereq && datreq && datwe);
			exp_xprog <= xprog_next;
			exp_xpabort <= (exp_xprog || exp_xpabort) && !exp_gate && (exp_xpabort || !progreq);
			if (exp_bigwr) begin
				exp_big <= gpu_din[2:0];
				exp_lock <= 1'b0;
			end
		end
	end

	a_reset_values: assert property (@(posedge sys_clk) !resetl |=>
		({big_instr, big_pix, big_io} == 3'b011) && (lock == $past(reset_lock))
		&& !gpu_memw && !datack && !gateack && !progserv && !progack)
		else fail_check("state after reset is wrong");
	a_priority: assert property (@(posedge sys_clk) disable iff (!resetl)
		{datack, gateack, progserv, gpu_memw} == {exp_dat, exp_gate, exp_prog, exp_memw})
		else fail_check("grant or write flag does not follow request priority");
	a_address: assert property (@(posedge sys_clk) disable iff (!resetl)
		(gpu_addr == ref_addr) && (ram_addr == ref_addr[11:2]))
		else fail_check("bus address does not match the granted source");
	a_external: assert property (@(posedge sys_clk) disable iff (!resetl)
		(externalb == exp_ext) && (del_xld == (exp_dat && exp_ext && !datwe)))
		else fail_check("external flag or delayed load strobe wrong");
	a_progack: assert property (@(posedge sys_clk) disable iff (!resetl)
		progack == exp_progack)
		else fail_check("program ack wrong");
	a_reg_strobes: assert property (@(posedge sys_clk) disable iff (!resetl)
		(wr_vec == exp_wr) && (rd_vec == exp_rd)
		&& (dbgrd == (exp_rd[0] || exp_rd[5]))
		&& (ctrlwrgo == (ctrl_sel && exp_memw && ref_addr.regs.idx == mem_map_pkg::reg_ctrl)))
		else fail_check("register strobes do not match the register index");
	a_audio_strobes: assert property (@(posedge sys_clk) disable iff (!resetl)
		{modulowr, dacw, i2sw, accumrd, i2sr} == '0)
		else fail_check("audio register strobe active on graphics map");
	a_mem_enables: assert property (@(posedge sys_clk) disable iff (!resetl)
		{ramen[1], ramen[0], romen, bliten} == exp_mem_en)
		else fail_check("RAM, ROM or blitter enable wrong");
	a_endian: assert property (@(posedge sys_clk) disable iff (!resetl)
		({big_instr, big_pix, big_io} == exp_big) && (lock == exp_lock))
		else fail_check("endian register or lock wrong");
	a_read_data: assert property (@(posedge sys_clk) disable iff (!resetl)
		1'b1 |=> mem_data == $past(gpu_din))
		else fail_check("read data is not the previous bus data");
	a_write_data: assert property (@(posedge sys_clk) disable iff (!resetl)
		((exp_io && exp_memw) ? (gpu_data_out == cpudata)
		: (exp_io || gpu_data_out == exp_dstd)))
		else fail_check("write data mux wrong");
	a_output_enable: assert property (@(posedge sys_clk) disable iff (!resetl)
		gpu_data_oe == exp_oe)
		else fail_check("bus output enable wrong");

	task automatic apply_reset(input logic lock_strap);
		@(negedge sys_clk);
		resetl = 1'b0;
		reset_lock = lock_strap;
		{ioreq, gatereq, datreq, progreq, pabort} = 5'b0;
		// Store latch fills during reset
		go = 1'b1;
		dstdgate = 1'b0;
		repeat (reset_cycles) @(negedge sys_clk);
		resetl = 1'b1;
	endtask

	// Prog fetch outside the window, then the gateway completes it
	task automatic external_fetch();
		@(negedge sys_clk);
		progaddr = 22'h001234;
		pabort = 1'b0;
		progreq = 1'b1;
		do @(negedge sys_clk); while (!progserv);
		gatereq = 1'b1;
		do @(negedge sys_clk); while (!progack);
		gatereq = 1'b0;
		progreq = 1'b0;
	endtask

	task automatic drive_random();
		logic [31:0] r;
		logic [4:0] idx;
		draw(16, r);
		ioreq = r[0] & r[1];
		gatereq = r[2] & r[3] & r[4];
		datreq = r[5];
		progreq = r[6] | r[7];
		pabort = r[8] & r[9] & r[10];
		iowr = r[11];
		datwe = r[12];
		go = r[13];
		dstdgate = r[14] & r[15];
		draw(32, cpudata);
		draw(32, dstd);
		draw(32, gpu_din);
		// Half the register picks hit the endian register
		draw(6, r);
		idx = r[0] ? 5'd3 : r[5:1];
		draw(3, r);
		// Host control block picks split between the registers and the lower half
		if (r[1:0] != 2'b00)
			cpuaddr = {mem_map_pkg::ctrl_block, (r[2] ? mem_map_pkg::ctrl_group : 2'b00), idx};
		else begin
			draw(13, r);
			cpuaddr = r[12:0];
		end
		draw(2, r);
		if (r[1:0] == 2'b00)
			dataddr = {mem_map_pkg::gfx_local_page, mem_map_pkg::ctrl_block,
				mem_map_pkg::ctrl_group, idx, 2'b00};
		else if (r[1:0] == 2'b01) begin
			draw(15, r);
			dataddr = {mem_map_pkg::gfx_local_page, r[14:0]};
		end else begin
			draw(24, r);
			dataddr = r[23:0];
		end
		draw(1, r);
		if (r[0]) begin
			draw(13, r);
			progaddr = {mem_map_pkg::gfx_local_page, r[12:0]};
		end else begin
			draw(22, r);
			progaddr = r[21:0];
		end
	endtask

	initial begin
		lfsr_state = 32'h8bdbcdcc;
		resetl = 1'b0;
		reset_lock = 1'b1;
		{ioreq, iowr, gatereq, datreq, datwe, progreq, pabort} = 7'b0;
		go = 1'b1;
		dstdgate = 1'b0;
		cpuaddr = '0;
		dataddr = '0;
		progaddr = '0;
		cpudata = '0;
		dstd = '0;
		gpu_din = '0;
		// Locked start, host register and RAM0 access shut out
		apply_reset(1'b1);
		external_fetch();
		repeat (rand_cycles) begin
			@(negedge sys_clk);
			drive_random();
		end
		// Unlocked start
		apply_reset(1'b0);
		repeat (rand_cycles) begin
			@(negedge sys_clk);
			drive_random();
		end
		@(negedge sys_clk);
		{ioreq, gatereq, datreq, progreq} = 4'b0;
		repeat (3) @(negedge sys_clk);
		$display("Summary: %0d check failures, %0d cycles", error_count, cycle_count);
		if (error_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	always @(posedge sys_clk) begin
		cycle_count++;
		if (cycle_count > timeout_cycles) begin
			$display("Run stopped: no finish after %0d cycles", timeout_cycles);
			$display("Summary: %0d check failures, %0d cycles", error_count, cycle_count);
			$display("Test failures found");
			$finish;
		end
	end

endmodule

// ==== list.f ====
common/mem_map_pkg.sv
common/bus_pkg.sv
common/grant_if.sv
arbiter/mem_arbiter.sv
decode/addr_decode.sv
rtl/bus_datapath.sv
rtl/gpu_mem_top.sv
verif/tb_gpu_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and search the log for the pass message

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
sim_bin=Vtb_gpu_mem
log_file=sim.log

verilator --binary --timing --assert \
	--top-module tb_gpu_mem --Mdir "$obj_dir" -o "$sim_bin" -f list.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$obj_dir/$sim_bin" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q 'All tests passed!' "$log_file"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see $log_file"
	exit 1
fi
